/* common/engine_pkg.sv */
`default_nettype none

package engine_pkg;

	// Data path geometry
	localparam int lanes  = 16;     // Parallel lanes, also the longest burst
	localparam int word_w = 16;
	localparam int addr_w = 30;     // DMA addresses count 16-bit elements
	localparam int cnt_w  = 5;      // Holds 0..16
	localparam int sum_w  = 24;     // Pooling sum headroom for 16 atoms
	localparam int shift_w = 3;     // Average shift 0..4

	// Operation codes
	localparam int op_w = 3;
	localparam logic [op_w-1:0] op_conv  = 3'd1;
	localparam logic [op_w-1:0] op_mpool = 3'd4;
	localparam logic [op_w-1:0] op_apool = 3'd5;

	// Controller states
	localparam int st_w = 3;
	localparam logic [st_w-1:0] st_idle   = 3'd0;
	localparam logic [st_w-1:0] st_fetch  = 3'd1;   // Bursts in flight
	localparam logic [st_w-1:0] st_load   = 3'd2;   // Lanes take one atom
	localparam logic [st_w-1:0] st_write  = 3'd3;   // Result burst out
	localparam logic [st_w-1:0] st_finish = 3'd4;

endpackage

`default_nettype wire

/* engine/engine_ctrl.sv */
`default_nettype none

module engine_ctrl (
	input  wire                               clk,
	input  wire                               rst,
	input  wire                               engine_valid,
	input  wire  [engine_pkg::op_w-1:0]       op_type,
	input  wire  [31:0]                       op_num,
	input  wire  [engine_pkg::addr_w-1:0]     data_start_addr,
	input  wire  [engine_pkg::addr_w-1:0]     weight_start_addr,
	input  wire  [engine_pkg::addr_w-1:0]     result_start_addr,
	input  wire  [7:0]                        i_kernel,
	input  wire  [7:0]                        i_channel,
	output logic                              engine_ready,
	output logic                              p2_reads_en,
	output logic                              p3_reads_en,
	output logic                              p0_writes_en,
	output logic [engine_pkg::addr_w-1:0]     p0_addr,
	output logic [engine_pkg::addr_w-1:0]     p2_addr,
	output logic [engine_pkg::addr_w-1:0]     p3_addr,
	input  wire                               d_full,
	input  wire                               w_full,
	output logic                              deser_clear,
	output logic [engine_pkg::cnt_w-1:0]      para,
	output logic                              lane_load,
	output logic                              lane_clear,
	output logic                              wb_start,
	input  wire                               wb_done,
	output logic [engine_pkg::shift_w-1:0]    avg_shift
);

	logic [engine_pkg::st_w-1:0]    state;
	logic [engine_pkg::st_w-1:0]    state_nxt;
	logic [engine_pkg::op_w-1:0]    op_r;
	logic [31:0]                    num_r;
	logic [31:0]                    point_cnt;
	logic [7:0]                     kern_r;
	logic [7:0]                     atom_cnt;
	logic [engine_pkg::addr_w-1:0]  d_ptr;
	logic [engine_pkg::addr_w-1:0]  w_ptr;
	logic [engine_pkg::addr_w-1:0]  r_ptr;
	logic [engine_pkg::addr_w-1:0]  wbase_r;
	logic [engine_pkg::addr_w-1:0]  para_step;
	logic [engine_pkg::cnt_w-1:0]   para_cmd;
	logic [engine_pkg::shift_w-1:0] shift_cmd;
	logic                           cmd_take;
	logic                           is_conv;
	logic                           fetch_ok;
	logic                           fetch_go;
	logic                           last_atom;
	logic                           last_point;

	// New command only when idle or done
	assign cmd_take   = engine_valid && (state == engine_pkg::st_idle ||
	                                     state == engine_pkg::st_finish);
	assign is_conv    = (op_r == engine_pkg::op_conv);
	assign fetch_ok   = d_full && (w_full || !is_conv);   // Pooling needs no weights
	assign last_atom  = (atom_cnt + 8'd1 == kern_r);
	assign last_point = (point_cnt + 32'd1 == num_r);
	assign para_step  = {{(engine_pkg::addr_w - engine_pkg::cnt_w){1'b0}}, para};

	// Channel count capped at the lane count
	assign para_cmd = (i_channel > engine_pkg::lanes) ?
	                  engine_pkg::cnt_w'(engine_pkg::lanes) :
	                  i_channel[engine_pkg::cnt_w-1:0];

	always_comb begin
		case (i_kernel)
			8'd2:    shift_cmd = 3'd1;
			8'd4:    shift_cmd = 3'd2;
			8'd8:    shift_cmd = 3'd3;
			8'd16:   shift_cmd = 3'd4;
			default: shift_cmd = 3'd0;
		endcase
	end

	always_comb begin
		state_nxt = state;
		case (state)
			engine_pkg::st_idle,
			engine_pkg::st_finish: if (cmd_take) state_nxt = engine_pkg::st_fetch;
			engine_pkg::st_fetch:  if (fetch_ok) state_nxt = engine_pkg::st_load;
			engine_pkg::st_load:   state_nxt = last_atom ? engine_pkg::st_write :
			                                               engine_pkg::st_fetch;
			engine_pkg::st_write: begin
				if (wb_done)
					state_nxt = last_point ? engine_pkg::st_finish : engine_pkg::st_fetch;
			end
			default: state_nxt = engine_pkg::st_idle;
		endcase
	end

	// Every entry into fetch starts a fresh atom
	assign fetch_go    = (state != engine_pkg::st_fetch) && (state_nxt == engine_pkg::st_fetch);
	assign deser_clear = fetch_go;
	assign lane_clear  = fetch_go && (state != engine_pkg::st_load);  // First atom of a point
	assign lane_load   = (state == engine_pkg::st_load);

	// Enables drop once the burst is complete
	assign p2_reads_en  = (state == engine_pkg::st_fetch) && !d_full;
	assign p3_reads_en  = (state == engine_pkg::st_fetch) && is_conv && !w_full;
	assign p0_writes_en = (state == engine_pkg::st_write);

	assign p2_addr = d_ptr;
	assign p3_addr = w_ptr;
	assign p0_addr = r_ptr;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state        <= engine_pkg::st_idle;
			engine_ready <= 1'b0;
			wb_start     <= 1'b0;
			op_r         <= '0;
			num_r        <= '0;
			kern_r       <= '0;
			para         <= '0;
			avg_shift    <= '0;
			wbase_r      <= '0;
			d_ptr        <= '0;
			w_ptr        <= '0;
			r_ptr        <= '0;
			atom_cnt     <= '0;
			point_cnt    <= '0;
		end else begin
			state    <= state_nxt;
			wb_start <= (state == engine_pkg::st_load) && last_atom;  // Lanes settled by now
			if (cmd_take) begin
				op_r         <= op_type;
				num_r        <= op_num;
				kern_r       <= i_kernel;
				para         <= para_cmd;
				avg_shift    <= shift_cmd;
				wbase_r      <= weight_start_addr;
				d_ptr        <= data_start_addr;
				w_ptr        <= weight_start_addr;
				r_ptr        <= result_start_addr;
				atom_cnt     <= '0;
				point_cnt    <= '0;
				engine_ready <= 1'b0;
			end
			if (state == engine_pkg::st_load) begin
				d_ptr <= d_ptr + para_step;  // Atoms of all points are contiguous
				if (last_atom) begin
					atom_cnt <= '0;
					w_ptr    <= wbase_r;       // Same kernel for the next point
				end else begin
					atom_cnt <= atom_cnt + 8'd1;
					w_ptr    <= w_ptr + para_step;
				end
			end
			if (state == engine_pkg::st_write && wb_done) begin
				point_cnt <= point_cnt + 32'd1;
				r_ptr     <= r_ptr + para_step;
				if (last_point)
					engine_ready <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* engine/burst_deser.sv */
`default_nettype none

module burst_deser (
	input  wire                                           clk,
	input  wire                                           rst,
	input  wire                                           clear,
	input  wire  [engine_pkg::cnt_w-1:0]                  para,
	input  wire                                           ob_we,
	input  wire  [engine_pkg::word_w-1:0]                 ob_data,
	output logic                                          full,
	output logic [engine_pkg::lanes*engine_pkg::word_w-1:0] vec
);

	logic [engine_pkg::cnt_w-1:0] cnt;
	logic                         take;

	assign take = ob_we && !full;   // Extra words after a full burst are dropped

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt  <= '0;
			full <= 1'b0;
		end else if (clear) begin
			cnt  <= '0;
			full <= 1'b0;
		end else if (take) begin
			cnt <= cnt + 1'b1;
			if (cnt + 1'b1 == para)
				full <= 1'b1;
		end
	end

	// Unwritten slots stay zero after clear
	always_ff @(posedge clk) begin
		for (int i = 0; i < engine_pkg::lanes; i++) begin
			if (clear)
				vec[i*engine_pkg::word_w +: engine_pkg::word_w] <= '0;
			else if (take && int'(cnt) == i)
				vec[i*engine_pkg::word_w +: engine_pkg::word_w] <= ob_data;
		end
	end

endmodule

`default_nettype wire

/* engine/wb_ser.sv */
`default_nettype none

module wb_ser (
	input  wire                                           clk,
	input  wire                                           rst,
	input  wire                                           start,
	input  wire  [engine_pkg::cnt_w-1:0]                  para,
	input  wire  [engine_pkg::lanes*engine_pkg::word_w-1:0] vec,
	input  wire                                           ib_re,
	output logic [engine_pkg::word_w-1:0]                 ib_data,
	output logic                                          ib_valid,
	output logic                                          done
);

	logic [engine_pkg::lanes*engine_pkg::word_w-1:0] vec_r;
	logic [engine_pkg::cnt_w-1:0]                    idx;
	logic                                            send;

	assign send = ib_re && (idx != para);   // No words past the active lanes

	always_ff @(posedge clk) begin
		if (start)
			vec_r <= vec;
		if (send)
			ib_data <= vec_r[int'(idx)*engine_pkg::word_w +: engine_pkg::word_w];
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			idx      <= '0;
			ib_valid <= 1'b0;
			done     <= 1'b0;
		end else begin
			ib_valid <= send;
			done     <= ib_valid && (idx == para);  // Cycle after the last word
			if (start)
				idx <= '0;
			else if (send)
				idx <= idx + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hw/cmac.sv */
`default_nettype none

module cmac (
	input  wire                           clk,
	input  wire                           rst,
	input  wire                           clear,
	input  wire                           load,
	input  wire  [engine_pkg::word_w-1:0] data,
	input  wire  [engine_pkg::word_w-1:0] weight,
	output logic [engine_pkg::word_w-1:0] result
);

	logic signed [2*engine_pkg::word_w-1:0] prod;

	assign prod = $signed(data) * $signed(weight);

	// Accumulate wraps at 16 bits
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			result <= '0;
		else if (clear)
			result <= '0;
		else if (load)
			result <= result + prod[engine_pkg::word_w-1:0];
	end

endmodule

`default_nettype wire

/* hw/pool_lane.sv */
`default_nettype none

module pool_lane (
	input  wire                            clk,
	input  wire                            rst,
	input  wire                            clear,
	input  wire                            load,
	input  wire  [engine_pkg::word_w-1:0]  data,
	input  wire  [engine_pkg::shift_w-1:0] shift,
	output logic [engine_pkg::word_w-1:0]  max_result,
	output logic [engine_pkg::word_w-1:0]  avg_result
);

	logic signed [engine_pkg::word_w-1:0] max_r;
	logic signed [engine_pkg::sum_w-1:0]  sum_r;
	logic signed [engine_pkg::sum_w-1:0]  sum_shr;
	logic signed [engine_pkg::sum_w-1:0]  data_ext;
	logic                                 first;

	assign data_ext   = {{(engine_pkg::sum_w - engine_pkg::word_w){data[engine_pkg::word_w-1]}},
	                     data};
	assign sum_shr    = sum_r >>> shift;    // Divide by a power-of-two kernel
	assign avg_result = sum_shr[engine_pkg::word_w-1:0];
	assign max_result = max_r;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			max_r <= '0;
			sum_r <= '0;
			first <= 1'b1;
		end else if (clear) begin
			sum_r <= '0;
			first <= 1'b1;
		end else if (load) begin
			// First atom seeds the maximum
			if (first || $signed(data) > max_r)
				max_r <= data;
			sum_r <= sum_r + data_ext;
			first <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hw/engine.sv */
`default_nettype none

module engine (
	input  wire                           clk,
	input  wire                           rst,
	input  wire                           engine_valid,
	input  wire  [engine_pkg::op_w-1:0]   op_type,
	input  wire  [31:0]                   op_num,
	input  wire  [engine_pkg::addr_w-1:0] data_start_addr,
	input  wire  [engine_pkg::addr_w-1:0] weight_start_addr,
	input  wire  [engine_pkg::addr_w-1:0] result_start_addr,
	input  wire  [7:0]                    i_kernel,
	input  wire  [7:0]                    i_channel,
	output logic                          engine_ready,
	output logic                          p2_reads_en,
	output logic                          p3_reads_en,
	output logic                          p0_writes_en,
	output logic [engine_pkg::addr_w-1:0] p0_addr,
	output logic [engine_pkg::addr_w-1:0] p2_addr,
	output logic [engine_pkg::addr_w-1:0] p3_addr,
	input  wire  [engine_pkg::word_w-1:0] dma_p2_ob_data,
	input  wire  [engine_pkg::word_w-1:0] dma_p3_ob_data,
	input  wire                           dma_p2_ob_we,
	input  wire                           dma_p3_ob_we,
	input  wire                           dma_p0_ib_re,
	output logic [engine_pkg::word_w-1:0] dma_p0_ib_data,
	output logic                          dma_p0_ib_valid
);

	localparam int vec_w = engine_pkg::lanes * engine_pkg::word_w;

	logic                           d_full;
	logic                           w_full;
	logic                           deser_clear;
	logic [engine_pkg::cnt_w-1:0]   para;
	logic                           lane_load;
	logic                           lane_clear;
	logic                           wb_start;
	logic                           wb_done;
	logic [engine_pkg::shift_w-1:0] avg_shift;
	logic [vec_w-1:0]               d_vec;
	logic [vec_w-1:0]               w_vec;
	logic [vec_w-1:0]               conv_vec;
	logic [vec_w-1:0]               max_vec;
	logic [vec_w-1:0]               avg_vec;
	logic [vec_w-1:0]               res_vec;

	engine_ctrl u_ctrl (
		.clk               (clk),
		.rst               (rst),
		.engine_valid      (engine_valid),
		.op_type           (op_type),
		.op_num            (op_num),
		.data_start_addr   (data_start_addr),
		.weight_start_addr (weight_start_addr),
		.result_start_addr (result_start_addr),
		.i_kernel          (i_kernel),
		.i_channel         (i_channel),
		.engine_ready      (engine_ready),
		.p2_reads_en       (p2_reads_en),
		.p3_reads_en       (p3_reads_en),
		.p0_writes_en      (p0_writes_en),
		.p0_addr           (p0_addr),
		.p2_addr           (p2_addr),
		.p3_addr           (p3_addr),
		.d_full            (d_full),
		.w_full            (w_full),
		.deser_clear       (deser_clear),
		.para              (para),
		.lane_load         (lane_load),
		.lane_clear        (lane_clear),
		.wb_start          (wb_start),
		.wb_done           (wb_done),
		.avg_shift         (avg_shift)
	);

	// Data burst from p2
	burst_deser u_deser_d (
		.clk     (clk),
		.rst     (rst),
		.clear   (deser_clear),
		.para    (para),
		.ob_we   (dma_p2_ob_we),
		.ob_data (dma_p2_ob_data),
		.full    (d_full),
		.vec     (d_vec)
	);

	// Weight burst from p3
	burst_deser u_deser_w (
		.clk     (clk),
		.rst     (rst),
		.clear   (deser_clear),
		.para    (para),
		.ob_we   (dma_p3_ob_we),
		.ob_data (dma_p3_ob_data),
		.full    (w_full),
		.vec     (w_vec)
	);

	for (genvar g = 0; g < engine_pkg::lanes; g++) begin : gen_lane
		cmac u_cmac (
			.clk    (clk),
			.rst    (rst),
			.clear  (lane_clear),
			.load   (lane_load),
			.data   (d_vec[g*engine_pkg::word_w +: engine_pkg::word_w]),
			.weight (w_vec[g*engine_pkg::word_w +: engine_pkg::word_w]),
			.result (conv_vec[g*engine_pkg::word_w +: engine_pkg::word_w])
		);

		pool_lane u_pool (
			.clk        (clk),
			.rst        (rst),
			.clear      (lane_clear),
			.load       (lane_load),
			.data       (d_vec[g*engine_pkg::word_w +: engine_pkg::word_w]),
			.shift      (avg_shift),
			.max_result (max_vec[g*engine_pkg::word_w +: engine_pkg::word_w]),
			.avg_result (avg_vec[g*engine_pkg::word_w +: engine_pkg::word_w])
		);
	end

	assign res_vec = (op_type == engine_pkg::op_mpool) ? max_vec :
	                 (op_type == engine_pkg::op_apool) ? avg_vec : conv_vec;

	wb_ser u_ser (
		.clk      (clk),
		.rst      (rst),
		.start    (wb_start),
		.para     (para),
		.vec      (res_vec),
		.ib_re    (dma_p0_ib_re),
		.ib_data  (dma_p0_ib_data),
		.ib_valid (dma_p0_ib_valid),
		.done     (wb_done)
	);

endmodule

`default_nettype wire

/* bench/dma_model.sv */
`default_nettype none

module dma_model (
	input  wire                           clk,
	input  wire                           gaps,
	input  wire  [engine_pkg::cnt_w-1:0]  wr_len,
	input  wire                           p2_reads_en,
	input  wire  [engine_pkg::addr_w-1:0] p2_addr,
	input  wire                           p3_reads_en,
	input  wire  [engine_pkg::addr_w-1:0] p3_addr,
	input  wire                           p0_writes_en,
	input  wire  [engine_pkg::addr_w-1:0] p0_addr,
	output logic                          p2_ob_we,
	output logic [engine_pkg::word_w-1:0] p2_ob_data,
	output logic                          p3_ob_we,
	output logic [engine_pkg::word_w-1:0] p3_ob_data,
	output logic                          p0_ib_re,
	input  wire                           p0_ib_valid,
	input  wire  [engine_pkg::word_w-1:0] p0_ib_data
);

	logic [engine_pkg::word_w-1:0] dmem [0:4095];
	logic [engine_pkg::word_w-1:0] wmem [0:4095];
	logic [engine_pkg::word_w-1:0] rmem [0:4095];
	logic [engine_pkg::addr_w-1:0] p2_starts [0:255];   // First address of each data burst
	logic [engine_pkg::addr_w-1:0] p3_starts [0:255];
	logic [engine_pkg::addr_w-1:0] a;
	int p2_words;
	int p3_words;
	int p0_words;
	int p2_bursts;
	int p3_bursts;
	int p2_idx;
	int p3_idx;
	int wr_age;
	int wr_req;
	int cap_idx;

	initial begin
		for (int i = 0; i < 4096; i++)
			rmem[i] = 16'hc000 ^ 16'(i);   // Stale marker per address
		p2_ob_we = 1'b0;
		p3_ob_we = 1'b0;
		p0_ib_re = 1'b0;
		p2_ob_data = '0;
		p3_ob_data = '0;
		p2_words = 0;
		p3_words = 0;
		p0_words = 0;
		p2_bursts = 0;
		p3_bursts = 0;
		p2_idx = 0;
		p3_idx = 0;
		wr_age = 0;
		wr_req = 0;
		cap_idx = 0;
		forever begin
			@(posedge clk);
			#1;
			p2_ob_we = 1'b0;
			p3_ob_we = 1'b0;
			p0_ib_re = 1'b0;
			if (!p2_reads_en)
				p2_idx = 0;
			else if (!gaps || $urandom % 2 == 0) begin
				a = p2_addr + engine_pkg::addr_w'(p2_idx);
				if (p2_idx == 0) begin
					p2_starts[p2_bursts % 256] = p2_addr;
					p2_bursts++;
				end
				p2_ob_data = dmem[a[11:0]];
				p2_ob_we = 1'b1;
				p2_idx++;
				p2_words++;
			end
			if (!p3_reads_en)
				p3_idx = 0;
			else if (!gaps || $urandom % 2 == 0) begin
				a = p3_addr + engine_pkg::addr_w'(p3_idx);
				if (p3_idx == 0) begin
					p3_starts[p3_bursts % 256] = p3_addr;
					p3_bursts++;
				end
				p3_ob_data = wmem[a[11:0]];
				p3_ob_we = 1'b1;
				p3_idx++;
				p3_words++;
			end
			// Write requests start one cycle after the enable rises
			if (!p0_writes_en) begin
				wr_age = 0;
				wr_req = 0;
			end else begin
				wr_age++;
				if (wr_age >= 2 && wr_req < int'(wr_len) && (!gaps || $urandom % 2 == 0)) begin
					p0_ib_re = 1'b1;
					wr_req++;
				end
			end
			@(negedge clk);
			if (!p0_writes_en)
				cap_idx = 0;
			else if (p0_ib_valid) begin
				a = p0_addr + engine_pkg::addr_w'(cap_idx);
				rmem[a[11:0]] = p0_ib_data;
				cap_idx++;
				p0_words++;
			end
		end
	end

endmodule

`default_nettype wire

/* bench/engine_tb.sv */
`default_nettype none

module engine_tb;

	localparam int clk_period   = 8;
	localparam int atoms_total  = 89;    // Sum of points times kernel over all tests
	localparam int points_total = 14;
	localparam int cycle_bound  = 150;   // Per atom or result burst with gaps
	localparam int timeout      = (atoms_total + points_total) * cycle_bound * clk_period + 2000;

	logic                          clk;
	logic                          rst;
	logic                          engine_valid;
	logic [engine_pkg::op_w-1:0]   op_type;
	logic [31:0]                   op_num;
	logic [engine_pkg::addr_w-1:0] data_start_addr;
	logic [engine_pkg::addr_w-1:0] weight_start_addr;
	logic [engine_pkg::addr_w-1:0] result_start_addr;
	logic [7:0]                    i_kernel;
	logic [7:0]                    i_channel;
	logic                          engine_ready;
	logic                          p2_reads_en;
	logic                          p3_reads_en;
	logic                          p0_writes_en;
	logic [engine_pkg::addr_w-1:0] p0_addr;
	logic [engine_pkg::addr_w-1:0] p2_addr;
	logic [engine_pkg::addr_w-1:0] p3_addr;
	logic [engine_pkg::word_w-1:0] p2_data;
	logic [engine_pkg::word_w-1:0] p3_data;
	logic [engine_pkg::word_w-1:0] p0_data;
	logic                          p2_we;
	logic                          p3_we;
	logic                          p0_re;
	logic                          p0_valid;
	logic                          gaps;
	logic [engine_pkg::cnt_w-1:0]  wr_len;

	engine dut (
		.clk (clk), .rst (rst), .engine_valid (engine_valid), .op_type (op_type),
		.op_num (op_num), .data_start_addr (data_start_addr),
		.weight_start_addr (weight_start_addr), .result_start_addr (result_start_addr),
		.i_kernel (i_kernel), .i_channel (i_channel), .engine_ready (engine_ready),
		.p2_reads_en (p2_reads_en), .p3_reads_en (p3_reads_en), .p0_writes_en (p0_writes_en),
		.p0_addr (p0_addr), .p2_addr (p2_addr), .p3_addr (p3_addr),
		.dma_p2_ob_data (p2_data), .dma_p3_ob_data (p3_data), .dma_p2_ob_we (p2_we),
		.dma_p3_ob_we (p3_we), .dma_p0_ib_re (p0_re), .dma_p0_ib_data (p0_data),
		.dma_p0_ib_valid (p0_valid)
	);

	dma_model dma (
		.clk (clk), .gaps (gaps), .wr_len (wr_len),
		.p2_reads_en (p2_reads_en), .p2_addr (p2_addr), .p3_reads_en (p3_reads_en),
		.p3_addr (p3_addr), .p0_writes_en (p0_writes_en), .p0_addr (p0_addr),
		.p2_ob_we (p2_we), .p2_ob_data (p2_data), .p3_ob_we (p3_we), .p3_ob_data (p3_data),
		.p0_ib_re (p0_re), .p0_ib_valid (p0_valid), .p0_ib_data (p0_data)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		#(timeout);
		fail_run("Watchdog expired before the tests finished");
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			fail_run($sformatf("ERROR at time %0t: %s is 0x%0h, expected 0x%0h",
			                   $time, name, got, exp));
	endtask

	// Reference for one lane of one output point
	function automatic logic [15:0] expected_word(input logic [2:0] op, input int n, input int c,
	                                              input int kern, input int para,
	                                              input int dbase, input int wbase);
		logic signed [15:0] d;
		logic signed [15:0] w;
		logic signed [15:0] mx;
		logic signed [15:0] acc;
		logic signed [31:0] prod;
		logic signed [23:0] sum;
		logic signed [23:0] shr;
		acc = '0;
		mx = '0;
		sum = '0;
		for (int k = 0; k < kern; k++) begin
			d = dma.dmem[dbase + (n * kern + k) * para + c];
			w = dma.wmem[wbase + k * para + c];
			prod = d * w;
			acc = acc + prod[15:0];   // Wraps at 16 bits
			if (k == 0 || d > mx)
				mx = d;
			sum = sum + 24'(d);
		end
		shr = sum >>> $clog2(kern);
		if (op == engine_pkg::op_mpool)
			return mx;
		else if (op == engine_pkg::op_apool)
			return shr[15:0];
		return acc;
	endfunction

	task automatic start_op(input logic [2:0] op, input int num, input int dbase, input int wbase,
	                        input int rbase, input int kern, input int chan);
		@(posedge clk);
		#1;
		op_type = op;
		op_num = num;
		data_start_addr = dbase;
		weight_start_addr = wbase;
		result_start_addr = rbase;
		i_kernel = kern;
		i_channel = chan;
		wr_len = (chan > 16) ? 5'd16 : 5'(chan);
		engine_valid = 1'b1;
		@(posedge clk);
		#1;
		engine_valid = 1'b0;
		check("engine_ready", engine_ready, 0);   // Falls once the command is taken
	endtask

	task automatic wait_ready(input int limit);
		int cnt;
		cnt = 0;
		while (!engine_ready && cnt < limit) begin
			@(posedge clk);
			#1;
			cnt++;
		end
		if (!engine_ready)
			fail_run("The engine did not signal done within its cycle limit");
	endtask

	task automatic check_idle();
		repeat (3) @(posedge clk);
		#1;
		check("engine_ready", engine_ready, 0);
		check("p2_reads_en", p2_reads_en, 0);
		check("p3_reads_en", p3_reads_en, 0);
		check("p0_writes_en", p0_writes_en, 0);
		check("p2 words read", dma.p2_words, 0);
		check("p3 words read", dma.p3_words, 0);
		check("p0 words written", dma.p0_words, 0);
	endtask

	task automatic run_layer(input logic [2:0] op, input int num, input int kern, input int chan,
	                         input int dbase, input int wbase, input int rbase, input bit neg);
		int para;
		int p2_w0;
		int p3_w0;
		int p0_w0;
		int b2_0;
		int b3_0;
		int addr;
		bit conv;
		para = (chan > 16) ? 16 : chan;
		conv = (op == engine_pkg::op_conv);
		for (int i = 0; i < num * kern * para; i++)
			dma.dmem[dbase + i] = neg ? 16'(-1 - int'($urandom % 3000)) : 16'($urandom);
		if (conv)
			for (int i = 0; i < kern * para; i++)
				dma.wmem[wbase + i] = 16'($urandom);
		p2_w0 = dma.p2_words;
		p3_w0 = dma.p3_words;
		p0_w0 = dma.p0_words;
		b2_0 = dma.p2_bursts;
		b3_0 = dma.p3_bursts;
		start_op(op, num, dbase, wbase, rbase, kern, chan);
		wait_ready((num * kern + num) * cycle_bound);
		check("p2 words read", dma.p2_words - p2_w0, num * kern * para);
		check("p3 words read", dma.p3_words - p3_w0, conv ? num * kern * para : 0);
		check("p0 words written", dma.p0_words - p0_w0, num * para);
		for (int b = 0; b < num * kern; b++) begin
			check($sformatf("p2_addr of burst %0d", b), dma.p2_starts[(b2_0 + b) % 256],
			      dbase + b * para);
			if (conv)
				check($sformatf("p3_addr of burst %0d", b), dma.p3_starts[(b3_0 + b) % 256],
				      wbase + (b % kern) * para);
		end
		for (int n = 0; n < num; n++) begin
			for (int c = 0; c < para; c++) begin
				addr = rbase + n * para + c;
				check($sformatf("result word at %0d", addr), dma.rmem[addr],
				      expected_word(op, n, c, kern, para, dbase, wbase));
			end
		end
	endtask

	initial begin
		void'($urandom(32'h615));
		rst = 1'b1;
		engine_valid = 1'b0;
		op_type = '0;
		op_num = '0;
		data_start_addr = '0;
		weight_start_addr = '0;
		result_start_addr = '0;
		i_kernel = '0;
		i_channel = '0;
		gaps = 1'b0;
		wr_len = '0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		check_idle();
		run_layer(engine_pkg::op_conv, 3, 9, 16, 0, 512, 1024, 1'b0);
		run_layer(engine_pkg::op_conv, 2, 9, 5, 1200, 1400, 1500, 1'b0);
		gaps = 1'b1;   // DMA back-pressure from here on
		run_layer(engine_pkg::op_mpool, 3, 4, 16, 1600, 0, 1900, 1'b1);
		run_layer(engine_pkg::op_apool, 2, 8, 16, 2000, 0, 2300, 1'b0);
		run_layer(engine_pkg::op_conv, 2, 4, 16, 2400, 2600, 2700, 1'b0);
		repeat (3) @(posedge clk);   // Done level holds until the next command
		#1;
		check("engine_ready", engine_ready, 1);
		run_layer(engine_pkg::op_apool, 2, 4, 7, 2800, 0, 2900, 1'b1);   // Back to back
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
common/engine_pkg.sv
engine/engine_ctrl.sv
engine/burst_deser.sv
engine/wb_ser.sv
hw/cmac.sv
hw/pool_lane.sv
hw/engine.sv
bench/dma_model.sv
bench/engine_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module engine_tb -f sources.f -o engine_sim

out=$(./obj_dir/engine_sim 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "^Regression passed$"; then
	exit 0
fi
exit 1
